//--- Bender.yml
package:
  name: rv32i_decoder

sources:
  - verilog/decode_pkg.sv
  - verilog/dec_bus_if.sv
  - verilog/op_decoder.sv
  - verilog/operand_decoder.sv
  - verilog/issue_gate.sv
  - verilog/decode_stage_reg.sv
  - verilog/decoder_top.sv
  - target: test
    files:
      - tb/tb_decoder_top.sv

//--- filelist.f
verilog/decode_pkg.sv
verilog/dec_bus_if.sv
verilog/op_decoder.sv
verilog/operand_decoder.sv
verilog/issue_gate.sv
verilog/decode_stage_reg.sv
verilog/decoder_top.sv
tb/tb_decoder_top.sv

//--- tb/tb_decoder_top.sv
`timescale 1ns/1ps

module tb_decoder_top import decode_pkg::*; ();

    localparam int test_cycles = 6 + 1000 + 400 + 200 + 200 + 64 + 2;
    localparam int cycle_limit = test_cycles * 3 / 2;
    localparam logic [6:0] legal_opcs [9] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
        OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};
    localparam op_t imm_ops [8] = '{ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, ORI, ANDI};
    localparam op_t reg_ops [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};

    logic clk, rst, rdy, flush, fet_ready, fet_jump_pred, lsb_full, rob_full, rs_full;
    inst_t fet_inst;
    addr_t fet_inst_addr;
    logic dec_stall, dec_ready, dec_jump_pred;
    op_t dec_op;
    reg_idx_t dec_rd, dec_rs1, dec_rs2;
    imm_t dec_imm;
    addr_t dec_inst_addr;

    logic checking = 1'b0;
    logic exp_ready;
    logic [85:0] exp_data;  // {op, rd, rs1, rs2, imm, pred, addr}
    logic [63:0] seen = '0;
    int errors = 0;
    int errs_mark = 0;
    int tests_run = 0;
    int cycle_count = 0;

    wire [85:0] data = {dec_op, dec_rd, dec_rs1, dec_rs2, dec_imm, dec_jump_pred, dec_inst_addr};
    wire [86:0] outs = {dec_ready, data};
    wire exp_stall;

    decoder_top dut0 (.*);

    function automatic logic [52:0] decode_ref(input inst_t i);
        logic [2:0] f3;
        op_t op;
        reg_idx_t rd, rs1, rs2;
        imm_t imm;
        f3 = i[14:12];
        op = OP_NONE;
        rd = i[11:7];
        rs1 = i[19:15];
        rs2 = i[24:20];
        imm = 32'($signed(i[31:20]));  // I type unless overridden
        case (i[6:0])
            OPC_LUI, OPC_AUIPC: begin
                op = (i[6:0] == OPC_LUI) ? LUI : AUIPC;
                {rs1, rs2} = '0;
                imm = i & 32'hffff_f000;
            end
            OPC_JAL: begin
                op = JAL;
                {rs1, rs2} = '0;
                imm = 32'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
            end
            OPC_JALR: begin
                op = JALR;
                rs2 = '0;
            end
            OPC_BRANCH: begin
                if (f3[2:1] != 2'b01)
                    op = f3[2] ? BLT + op_t'(f3[1:0]) : BEQ + op_t'(f3);
                rd = '0;
                imm = 32'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
            end
            OPC_LOAD: begin
                if (f3 <= 3'd2)
                    op = LB + op_t'(f3);
                else if (f3[2:1] == 2'b10)
                    op = LBU + op_t'(f3[0]);
                rs2 = '0;
            end
            OPC_STORE: begin
                if (f3 <= 3'd2)
                    op = SB + op_t'(f3);
                rd = '0;
                imm = 32'($signed({i[31:25], i[11:7]}));
            end
            OPC_OP_IMM: begin
                op = (f3 == 3'd5 && i[30]) ? SRAI : imm_ops[f3];
                rs2 = '0;
                if (f3[1:0] == 2'b01)
                    imm = {27'b0, i[24:20]};  // Shift amount
            end
            OPC_OP: begin
                op = reg_ops[f3];
                if (i[30] && f3 == 3'd0)
                    op = SUB;
                else if (i[30] && f3 == 3'd5)
                    op = SRA;
                imm = '0;
            end
            default: begin
                {rd, rs1, rs2} = '0;
                imm = '0;
            end
        endcase
        return {op, rd, rs1, rs2, imm};
    endfunction

    function automatic logic stall_ref(input logic ready, input op_t op,
                                       input logic rob, input logic lsb, input logic rs);
        if (!ready)
            return 1'b0;
        if (op == LUI || op == AUIPC || op == JAL)
            return rob;
        if (op >= LB && op <= SW)
            return rob || lsb;  // Memory class
        return rob || rs;
    endfunction

    function automatic inst_t random_inst();
        inst_t r;
        r = $urandom;
        r[6:0] = legal_opcs[$urandom % 9];
        return r;
    endfunction

    // Unknown opcode or a known one with an unlisted funct3
    function automatic inst_t illegal_inst(input logic unknown_opc);
        inst_t r;
        logic known;
        r = $urandom;
        if (unknown_opc) begin
            do begin
                known = 1'b0;
                r[6:0] = $urandom;
                foreach (legal_opcs[k])
                    known = known || (r[6:0] == legal_opcs[k]);
            end while (known);
        end else begin
            case ($urandom % 3)
                0: r[14:0] = {3'(2 + $urandom % 2), 5'(r[11:7]), OPC_BRANCH};
                1: r[14:0] = {(($urandom % 2) ? 3'd3 : 3'(6 + $urandom % 2)), 5'(r[11:7]),
                              OPC_LOAD};
                default: r[14:0] = {3'(3 + $urandom % 5), 5'(r[11:7]), OPC_STORE};
            endcase
        end
        return r;
    endfunction

    assign exp_stall = stall_ref(exp_ready, exp_data[85:80], rob_full, lsb_full, rs_full);

    always @(posedge clk) begin : scoreboard
        logic [52:0] word;
        word = decode_ref(fet_inst);
        if (rdy) begin
            if (rst) begin
                exp_ready <= 1'b0;
                exp_data <= '0;
            end else if (flush) begin
                exp_ready <= 1'b0;
            end else if (!exp_stall) begin
                exp_ready <= fet_ready;
                if (fet_ready) begin
                    exp_data <= {word, fet_jump_pred, fet_inst_addr};
                    seen[word[52:47]] <= 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    assert property (@(posedge clk) checking |-> outs == {exp_ready, exp_data})
        else begin
            errors++;
            $display("Fail at %0t: outputs %h, expected %h", $time, outs, {exp_ready, exp_data});
        end
    assert property (@(posedge clk) checking |-> dec_stall == exp_stall)
        else begin
            errors++;
            $display("Fail at %0t: dec_stall %b, expected %b", $time, dec_stall, exp_stall);
        end
    assert property (@(posedge clk) checking && rdy && !rst && !flush && dec_stall |=> $stable(outs))
        else begin
            errors++;
            $display("Fail at %0t: outputs moved during a stall", $time);
        end
    assert property (@(posedge clk) checking && rdy && !rst && (flush || (!dec_stall && !fet_ready))
                     |=> !dec_ready && !dec_stall && $stable(data))
        else begin
            errors++;
            $display("Fail at %0t: flush or idle fetch did not drop ready and hold data", $time);
        end
    assert property (@(posedge clk) checking && !rdy |=> $stable(outs))
        else begin
            errors++;
            $display("Fail at %0t: outputs moved while rdy was low", $time);
        end
    assert property (@(posedge clk) rdy && rst |=> outs == '0 && !dec_stall)
        else begin
            errors++;
            $display("Fail at %0t: outputs not cleared by reset, got %h", $time, outs);
        end

    task automatic present(input inst_t i);
        fet_inst <= i;
        fet_inst_addr <= $urandom;
        fet_jump_pred <= $urandom % 2;
    endtask

    task automatic end_test(input string name);
        $display("Test %-14s done with %0d errors", name, errors - errs_mark);
        errs_mark = errors;
        tests_run++;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        void'($urandom(32'hfca7_c32b));
        rst = 1'b1;
        rdy = 1'b1;
        flush = 1'b0;
        fet_ready = 1'b0;
        fet_inst = '0;
        fet_inst_addr = '0;
        fet_jump_pred = 1'b0;
        lsb_full = 1'b0;
        rob_full = 1'b0;
        rs_full = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        checking <= 1'b1;
        @(posedge clk);
        end_test("reset");

        repeat (1000) begin
            present(random_inst());
            fet_ready <= 1'b1;
            @(posedge clk);
        end
        end_test("random decode");
        assert (seen[37:1] == '1)
            else begin
                errors++;
                $display("Not every operation code was decoded during the random test");
            end

        repeat (400) begin
            present(random_inst());
            rob_full <= ($urandom % 4 == 0);
            lsb_full <= $urandom % 2;
            rs_full <= $urandom % 2;
            fet_ready <= ($urandom % 4 != 0);
            @(posedge clk);
        end
        {rob_full, lsb_full, rs_full} <= 3'b000;
        end_test("stall by class");

        repeat (200) begin
            present(random_inst());
            flush <= ($urandom % 4 == 0);
            fet_ready <= ($urandom % 3 != 0);
            @(posedge clk);
        end
        flush <= 1'b0;
        end_test("flush and idle");

        repeat (200) begin
            present(random_inst());
            rdy <= $urandom % 2;
            rst <= ($urandom % 8 == 0);  // Only takes effect with rdy high
            flush <= ($urandom % 4 == 0);
            fet_ready <= $urandom % 2;
            rob_full <= ($urandom % 4 == 0);
            @(posedge clk);
        end
        rdy <= 1'b1;
        rst <= 1'b0;
        flush <= 1'b0;
        rob_full <= 1'b0;
        end_test("rdy freeze");

        for (int n = 0; n < 64; n++) begin
            present(illegal_inst(n % 2));
            fet_ready <= 1'b1;
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);  // Let the last edge's assertions report
        end_test("illegal");

        $display("Tests run: %0d, checks failed: %0d", tests_run, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- verilog/dec_bus_if.sv
`timescale 1ns/1ps

interface dec_bus_if import decode_pkg::*; ();

    op_t      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    imm_t     imm;

    modport op_src (
        output op
    );

    modport field_src (
        output rd, rs1, rs2, imm
    );

    modport sink (
        input op, rd, rs1, rs2, imm
    );

endinterface

//--- verilog/decode_pkg.sv
package decode_pkg;

    localparam int unsigned xlen      = 32;
    localparam int unsigned reg_idx_w = 5;
    localparam int unsigned op_w      = 6;

    typedef logic [xlen-1:0]      inst_t;
    typedef logic [xlen-1:0]      addr_t;
    typedef logic [xlen-1:0]      imm_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [op_w-1:0]      op_t;

    // Major opcodes in inst[6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam op_t OP_NONE = 6'd0;  // Illegal or unsupported
    localparam op_t LUI     = 6'd1;
    localparam op_t AUIPC   = 6'd2;
    localparam op_t JAL     = 6'd3;
    localparam op_t JALR    = 6'd4;
    localparam op_t BEQ     = 6'd5;
    localparam op_t BNE     = 6'd6;
    localparam op_t BLT     = 6'd7;
    localparam op_t BGE     = 6'd8;
    localparam op_t BLTU    = 6'd9;
    localparam op_t BGEU    = 6'd10;
    localparam op_t LB      = 6'd11;
    localparam op_t LH      = 6'd12;
    localparam op_t LW      = 6'd13;
    localparam op_t LBU     = 6'd14;
    localparam op_t LHU     = 6'd15;
    localparam op_t SB      = 6'd16;
    localparam op_t SH      = 6'd17;
    localparam op_t SW      = 6'd18;
    localparam op_t ADDI    = 6'd19;
    localparam op_t SLTI    = 6'd20;
    localparam op_t SLTIU   = 6'd21;
    localparam op_t XORI    = 6'd22;
    localparam op_t ORI     = 6'd23;
    localparam op_t ANDI    = 6'd24;
    localparam op_t SLLI    = 6'd25;
    localparam op_t SRLI    = 6'd26;
    localparam op_t SRAI    = 6'd27;
    localparam op_t ADD     = 6'd28;
    localparam op_t SUB     = 6'd29;
    localparam op_t SLL     = 6'd30;
    localparam op_t SLT     = 6'd31;
    localparam op_t SLTU    = 6'd32;
    localparam op_t XOR     = 6'd33;
    localparam op_t SRL     = 6'd34;
    localparam op_t SRA     = 6'd35;
    localparam op_t OR      = 6'd36;
    localparam op_t AND     = 6'd37;

endpackage

//--- verilog/decode_stage_reg.sv
`timescale 1ns/1ps

module decode_stage_reg import decode_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        rdy,
    input logic        flush,
    input logic        stall,
    input logic        fet_ready,
    input logic        fet_jump_pred,
    input addr_t       fet_inst_addr,
    dec_bus_if.sink    bus,
    output logic       dec_ready,
    output op_t        dec_op,
    output logic       dec_jump_pred,
    output reg_idx_t   dec_rd,
    output reg_idx_t   dec_rs1,
    output reg_idx_t   dec_rs2,
    output imm_t       dec_imm,
    output addr_t      dec_inst_addr
);

    always_ff @(posedge clk) begin
        if (rdy) begin  // Global freeze covers reset too
            if (rst) begin
                dec_ready     <= 1'b0;
                dec_op        <= OP_NONE;
                dec_jump_pred <= 1'b0;
                dec_rd        <= '0;
                dec_rs1       <= '0;
                dec_rs2       <= '0;
                dec_imm       <= '0;
                dec_inst_addr <= '0;
            end else if (flush) begin
                dec_ready <= 1'b0;  // Data kept
            end else if (!stall) begin
                if (fet_ready) begin
                    dec_ready     <= 1'b1;
                    dec_op        <= bus.op;
                    dec_rd        <= bus.rd;
                    dec_rs1       <= bus.rs1;
                    dec_rs2       <= bus.rs2;
                    dec_imm       <= bus.imm;
                    dec_inst_addr <= fet_inst_addr;
                    dec_jump_pred <= fet_jump_pred;
                end else begin
                    dec_ready <= 1'b0;  // Bubble
                end
            end
        end
    end

endmodule

//--- verilog/decoder_top.sv
`timescale 1ns/1ps

module decoder_top import decode_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      rdy,
    input logic      flush,
    input logic      fet_ready,
    input inst_t     fet_inst,
    input addr_t     fet_inst_addr,
    input logic      fet_jump_pred,
    input logic      lsb_full,
    input logic      rob_full,
    input logic      rs_full,
    output logic     dec_stall,
    output logic     dec_ready,
    output op_t      dec_op,
    output logic     dec_jump_pred,
    output reg_idx_t dec_rd,
    output reg_idx_t dec_rs1,
    output reg_idx_t dec_rs2,
    output imm_t     dec_imm,
    output addr_t    dec_inst_addr
);

    logic stall;

    dec_bus_if bus0 ();

    op_decoder u_op_decoder (
        .inst (fet_inst),
        .bus  (bus0.op_src)
    );

    operand_decoder u_operand_decoder (
        .inst (fet_inst),
        .bus  (bus0.field_src)
    );

    // Checks the held op, not the incoming one
    issue_gate u_issue_gate (
        .dec_ready (dec_ready),
        .dec_op    (dec_op),
        .rob_full  (rob_full),
        .lsb_full  (lsb_full),
        .rs_full   (rs_full),
        .stall     (stall)
    );

    assign dec_stall = stall;

    decode_stage_reg u_stage_reg (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .flush         (flush),
        .stall         (stall),
        .fet_ready     (fet_ready),
        .fet_jump_pred (fet_jump_pred),
        .fet_inst_addr (fet_inst_addr),
        .bus           (bus0.sink),
        .dec_ready     (dec_ready),
        .dec_op        (dec_op),
        .dec_jump_pred (dec_jump_pred),
        .dec_rd        (dec_rd),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_imm       (dec_imm),
        .dec_inst_addr (dec_inst_addr)
    );

endmodule

//--- verilog/issue_gate.sv
`timescale 1ns/1ps

module issue_gate import decode_pkg::*; (
    input logic dec_ready,
    input op_t  dec_op,
    input logic rob_full,
    input logic lsb_full,
    input logic rs_full,
    output logic stall
);

    // Every op takes a ROB entry; the second unit depends on class
    always_comb begin
        stall = 1'b0;
        if (dec_ready) begin
            case (dec_op)
                LUI, AUIPC, JAL: begin
                    stall = rob_full;
                end
                LB, LH, LW, LBU, LHU, SB, SH, SW: begin
                    stall = rob_full || lsb_full;
                end
                default: begin
                    stall = rob_full || rs_full;
                end
            endcase
        end
    end

endmodule

//--- verilog/op_decoder.sv
`timescale 1ns/1ps

module op_decoder import decode_pkg::*; (
    input inst_t          inst,
    dec_bus_if.op_src     bus
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;  // Bit 30 selects SUB and arithmetic shifts

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    always_comb begin
        bus.op = OP_NONE;
        case (opcode)
            OPC_LUI:   bus.op = LUI;
            OPC_AUIPC: bus.op = AUIPC;
            OPC_JAL:   bus.op = JAL;
            OPC_JALR:  bus.op = JALR;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  bus.op = BEQ;
                    3'b001:  bus.op = BNE;
                    3'b100:  bus.op = BLT;
                    3'b101:  bus.op = BGE;
                    3'b110:  bus.op = BLTU;
                    3'b111:  bus.op = BGEU;
                    default: bus.op = OP_NONE;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  bus.op = LB;
                    3'b001:  bus.op = LH;
                    3'b010:  bus.op = LW;
                    3'b100:  bus.op = LBU;
                    3'b101:  bus.op = LHU;
                    default: bus.op = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  bus.op = SB;
                    3'b001:  bus.op = SH;
                    3'b010:  bus.op = SW;
                    default: bus.op = OP_NONE;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: bus.op = ADDI;
                    3'b001: bus.op = SLLI;
                    3'b010: bus.op = SLTI;
                    3'b011: bus.op = SLTIU;
                    3'b100: bus.op = XORI;
                    3'b101: bus.op = alt ? SRAI : SRLI;
                    3'b110: bus.op = ORI;
                    3'b111: bus.op = ANDI;
                endcase
            end
            OPC_OP: begin
                case (funct3)
                    3'b000: bus.op = alt ? SUB : ADD;
                    3'b001: bus.op = SLL;
                    3'b010: bus.op = SLT;
                    3'b011: bus.op = SLTU;
                    3'b100: bus.op = XOR;
                    3'b101: bus.op = alt ? SRA : SRL;
                    3'b110: bus.op = OR;
                    3'b111: bus.op = AND;
                endcase
            end
            default: bus.op = OP_NONE;
        endcase
    end

endmodule

//--- verilog/operand_decoder.sv
`timescale 1ns/1ps

module operand_decoder import decode_pkg::*; (
    input inst_t          inst,
    dec_bus_if.field_src  bus
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_shift_imm;

    assign opcode       = inst[6:0];
    assign funct3       = inst[14:12];
    assign is_shift_imm = (opcode == OPC_OP_IMM) && (funct3 == 3'b001 || funct3 == 3'b101);

    always_comb begin
        bus.rd  = '0;
        bus.rs1 = '0;
        bus.rs2 = '0;
        bus.imm = '0;
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin  // U type
                bus.rd  = inst[11:7];
                bus.imm = {inst[31:12], 12'b0};
            end
            OPC_JAL: begin  // J type
                bus.rd  = inst[11:7];
                bus.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OPC_BRANCH: begin  // B type
                bus.rs1 = inst[19:15];
                bus.rs2 = inst[24:20];
                bus.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OPC_STORE: begin  // S type
                bus.rs1 = inst[19:15];
                bus.rs2 = inst[24:20];
                bus.imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            end
            OPC_OP: begin  // R type has no immediate
                bus.rd  = inst[11:7];
                bus.rs1 = inst[19:15];
                bus.rs2 = inst[24:20];
            end
            OPC_JALR, OPC_OP_IMM, OPC_LOAD: begin  // I type
                bus.rd  = inst[11:7];
                bus.rs1 = inst[19:15];
                if (is_shift_imm)
                    bus.imm = {27'b0, inst[24:20]};  // Shamt only
                else
                    bus.imm = {{21{inst[31]}}, inst[30:20]};
            end
            default: ;
        endcase
    end

endmodule
